//--- sdio_pkg.sv
package sdio_pkg;

    localparam int CRC_LEN   = 16; // crc bits per lane
    localparam int NUM_LANES = 4;
    localparam int BYTE_W    = 8;

    // x^16 + x^12 + x^5 + 1
    localparam logic [CRC_LEN-1:0] CRC16_POLY = 16'h1021;

    typedef logic [BYTE_W-1:0]    byte_t;
    typedef logic [NUM_LANES-1:0] lanes_t;  // one sample of dat[3:0]
    typedef logic [15:0]          blk_len_t;
    typedef logic [CRC_LEN-1:0]   crc_t;

    typedef enum logic {
        BUS_1BIT = 1'b0,
        BUS_4BIT = 1'b1
    } bus_width_e;

    // receive fsm
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_START = 3'd1, // wait for start bit
        ST_DATA  = 3'd2,
        ST_PUSH  = 3'd3, // byte into fifo, card clock paused
        ST_CRC   = 3'd4,
        ST_END   = 3'd5,
        ST_NEXT  = 3'd6  // block done, decide next block or finish
    } rx_state_e;

endpackage

//--- sdio_crc16.sv
`timescale 1ns/1ps

module sdio_crc16 (
    input  logic           sd_clk,
    input  logic           rstn,
    input  logic           clr_i,
    input  logic           en_i,
    input  logic           bit_i,
    output sdio_pkg::crc_t crc_o
);

    sdio_pkg::crc_t crc_q;
    logic           fb;

    assign fb = bit_i ^ crc_q[sdio_pkg::CRC_LEN-1]; // feedback from msb

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            crc_q <= '0;
        end else if (clr_i) begin
            crc_q <= '0;
        end else if (en_i) begin
            crc_q <= {crc_q[sdio_pkg::CRC_LEN-2:0], 1'b0} ^ (fb ? sdio_pkg::CRC16_POLY : '0);
        end
    end

    assign crc_o = crc_q;

endmodule

//--- sdio_rx_deser.sv
`timescale 1ns/1ps

module sdio_rx_deser (
    input  logic                 sd_clk,
    input  logic                 rstn,
    input  logic                 sd_rst_i,
    input  sdio_pkg::blk_len_t   block_size_i,
    input  sdio_pkg::blk_len_t   block_count_i,  // 0 means endless
    input  sdio_pkg::bus_width_e bus_width_i,
    input  logic [1:0]           pad_sel_i,
    input  logic                 dat_start_i,
    input  logic                 rx_en_i,
    input  sdio_pkg::lanes_t     dat_i,
    input  logic                 full_i,
    output logic                 push_o,
    output sdio_pkg::byte_t      push_byte_o,
    output logic                 crc_err_event_o,
    output logic                 end_err_event_o,
    output logic                 blk_end_event_o,
    output logic                 dat_done_o,
    output logic                 dat_busy_o,
    output logic                 clk_pause_o
);

    localparam int CRC_CW = $clog2(sdio_pkg::CRC_LEN);
    localparam logic [CRC_CW-1:0] CRC_LAST = CRC_CW'(sdio_pkg::CRC_LEN - 1);

    sdio_pkg::rx_state_e state_q;
    sdio_pkg::rx_state_e state_d;

    logic [2:0]         bit_cnt_q;
    logic [2:0]         bit_max;
    sdio_pkg::blk_len_t byte_cnt_q;
    sdio_pkg::blk_len_t blk_cnt_q;
    logic [CRC_CW-1:0]  crc_cnt_q;
    sdio_pkg::byte_t    byte_q;
    logic               crc_err_q;

    logic             four_bit;
    sdio_pkg::lanes_t rx_bits;   // lane 0 replaced by the pad lane in 1-bit mode
    sdio_pkg::lanes_t act_mask;
    sdio_pkg::lanes_t crc_bits;
    sdio_pkg::crc_t   crc_rem [sdio_pkg::NUM_LANES];

    logic last_bit, last_byte, last_crc, last_blk;
    logic start_flag, end_ok, crc_miss;
    logic data_en, crc_clr, end_smp;

    assign four_bit = (bus_width_i == sdio_pkg::BUS_4BIT);
    assign act_mask = four_bit ? '1 : sdio_pkg::lanes_t'(1);
    assign bit_max  = four_bit ? 3'd1 : 3'd7; // two nibbles or eight bits

    always_comb begin
        rx_bits = dat_i;
        if (!four_bit)
            rx_bits[0] = dat_i[pad_sel_i];
    end

    assign start_flag = ((rx_bits & act_mask) == '0);
    assign end_ok     = ((rx_bits & act_mask) == act_mask);
    assign crc_miss   = |((rx_bits ^ crc_bits) & act_mask);

    assign last_bit  = (bit_cnt_q == bit_max);
    assign last_byte = (byte_cnt_q == block_size_i);
    assign last_crc  = (crc_cnt_q == CRC_LAST);
    assign last_blk  = (block_count_i != '0) && (blk_cnt_q == block_count_i);

    assign data_en = (state_q == sdio_pkg::ST_DATA) && rx_en_i;
    assign crc_clr = (state_q == sdio_pkg::ST_START);
    assign end_smp = (state_q == sdio_pkg::ST_END) && rx_en_i;

    // one crc per lane, remainders freeze once data ends
    for (genvar l = 0; l < sdio_pkg::NUM_LANES; l++) begin : g_lane
        sdio_crc16 i_crc (
            .sd_clk (sd_clk),
            .rstn   (rstn),
            .clr_i  (crc_clr),
            .en_i   (data_en & act_mask[l]),
            .bit_i  (rx_bits[l]),
            .crc_o  (crc_rem[l])
        );
        assign crc_bits[l] = crc_rem[l][CRC_LAST - crc_cnt_q]; // msb first
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            sdio_pkg::ST_IDLE:  if (dat_start_i) state_d = sdio_pkg::ST_START;
            sdio_pkg::ST_START: if (rx_en_i && start_flag) state_d = sdio_pkg::ST_DATA;
            sdio_pkg::ST_DATA:  if (rx_en_i && last_bit) state_d = sdio_pkg::ST_PUSH;
            sdio_pkg::ST_PUSH: begin
                if (!full_i)
                    state_d = last_byte ? sdio_pkg::ST_CRC : sdio_pkg::ST_DATA;
            end
            sdio_pkg::ST_CRC:   if (rx_en_i && last_crc) state_d = sdio_pkg::ST_END;
            sdio_pkg::ST_END:   if (rx_en_i) state_d = sdio_pkg::ST_NEXT;
            sdio_pkg::ST_NEXT:  state_d = last_blk ? sdio_pkg::ST_IDLE : sdio_pkg::ST_START;
            default:            state_d = sdio_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn)
            state_q <= sdio_pkg::ST_IDLE;
        else if (sd_rst_i)
            state_q <= sdio_pkg::ST_IDLE;
        else
            state_q <= state_d;
    end

    // counters, re-armed from idle and from each start bit
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            bit_cnt_q  <= '0;
            byte_cnt_q <= '0;
            blk_cnt_q  <= '0;
            crc_cnt_q  <= '0;
            crc_err_q  <= 1'b0;
        end else begin
            case (state_q)
                sdio_pkg::ST_IDLE: blk_cnt_q <= '0;
                sdio_pkg::ST_START: begin
                    if (rx_en_i && start_flag) begin
                        bit_cnt_q  <= '0;
                        byte_cnt_q <= '0;
                        crc_cnt_q  <= '0;
                        crc_err_q  <= 1'b0;
                    end
                end
                sdio_pkg::ST_DATA: begin
                    if (rx_en_i) begin
                        if (last_bit) begin
                            bit_cnt_q  <= '0;
                            byte_cnt_q <= byte_cnt_q + 1'b1; // counts finished bytes
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                sdio_pkg::ST_CRC: begin
                    if (rx_en_i) begin
                        crc_cnt_q <= crc_cnt_q + 1'b1;
                        if (crc_miss)
                            crc_err_q <= 1'b1; // sticky until next start bit
                    end
                end
                sdio_pkg::ST_END: if (rx_en_i) blk_cnt_q <= blk_cnt_q + 1'b1;
                default: ;
            endcase
        end
    end

    // byte assembly, msb first, high nibble first in 4-bit mode
    always_ff @(posedge sd_clk) begin
        if (data_en) begin
            if (four_bit)
                byte_q <= {byte_q[3:0], rx_bits};
            else
                byte_q <= {byte_q[6:0], rx_bits[0]};
        end
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            crc_err_event_o <= 1'b0;
            end_err_event_o <= 1'b0;
            blk_end_event_o <= 1'b0;
        end else if (sd_rst_i) begin
            crc_err_event_o <= 1'b0;
            end_err_event_o <= 1'b0;
            blk_end_event_o <= 1'b0;
        end else begin
            crc_err_event_o <= end_smp && crc_err_q;
            end_err_event_o <= end_smp && !end_ok; // every active lane must be high
            blk_end_event_o <= end_smp;
        end
    end

    assign push_o      = (state_q == sdio_pkg::ST_PUSH) && !full_i;
    assign push_byte_o = byte_q;
    assign clk_pause_o = (state_q == sdio_pkg::ST_PUSH); // host freezes card clock
    assign dat_busy_o  = (state_q != sdio_pkg::ST_IDLE);
    assign dat_done_o  = (state_q == sdio_pkg::ST_NEXT) && last_blk;

    a_no_push_full: assert property (@(posedge sd_clk) disable iff (!rstn)
        push_o |-> !full_i)
        else $error("byte pushed into a full fifo");

    a_legal_state: assert property (@(posedge sd_clk) disable iff (!rstn)
        state_q inside {sdio_pkg::ST_IDLE, sdio_pkg::ST_START, sdio_pkg::ST_DATA,
                        sdio_pkg::ST_PUSH, sdio_pkg::ST_CRC, sdio_pkg::ST_END,
                        sdio_pkg::ST_NEXT})
        else $error("receiver fsm in illegal state");

endmodule

//--- sdio_rx_fifo.sv
`timescale 1ns/1ps

module sdio_rx_fifo #(
    parameter int FIFO_DEPTH = 8 // power of two
) (
    input  logic            sd_clk,
    input  logic            rstn,
    input  logic            sd_rst_i,
    input  logic            push_i,
    input  sdio_pkg::byte_t push_byte_i,
    output logic            full_o,
    input  logic            pop_i,
    output sdio_pkg::byte_t pop_byte_o,
    output logic            empty_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    sdio_pkg::byte_t mem_q [FIFO_DEPTH];
    logic [AW:0]     wr_ptr_q;   // top bit marks the wrap
    logic [AW:0]     rd_ptr_q;

    always_ff @(posedge sd_clk) begin
        if (push_i)
            mem_q[wr_ptr_q[AW-1:0]] <= push_byte_i;
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (sd_rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    // same slot, opposite lap
    assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    assign pop_byte_o = mem_q[rd_ptr_q[AW-1:0]]; // show-ahead

    a_no_pop_empty: assert property (@(posedge sd_clk) disable iff (!rstn)
        pop_i |-> !empty_o)
        else $error("pop from an empty fifo");

endmodule

//--- sdio_dma_wr.sv
`timescale 1ns/1ps

module sdio_dma_wr (
    input  logic            sd_clk,
    input  logic            rstn,
    input  logic            sd_rst_i,
    input  logic            empty_i,
    input  sdio_pkg::byte_t pop_byte_i,
    output logic            pop_o,
    input  logic            dma_rdy_i,
    output sdio_pkg::byte_t dma_byte_o,
    output logic            dma_wr_o
);

    assign pop_o = !empty_i && dma_rdy_i;

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn)
            dma_wr_o <= 1'b0;
        else if (sd_rst_i)
            dma_wr_o <= 1'b0;
        else
            dma_wr_o <= pop_o; // one pulse per popped byte
    end

    always_ff @(posedge sd_clk) begin
        if (pop_o)
            dma_byte_o <= pop_byte_i;
    end

    // a write always follows a ready cycle
    a_wr_needs_rdy: assert property (@(posedge sd_clk) disable iff (!rstn)
        dma_wr_o && !dma_rdy_i |=> !dma_wr_o)
        else $error("dma write issued while dma not ready");

endmodule

//--- sdio_rx_top.sv
`timescale 1ns/1ps

module sdio_rx_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 sd_clk,
    input  logic                 rstn,
    input  logic                 sd_rst_i,
    input  sdio_pkg::blk_len_t   block_size_i,
    input  sdio_pkg::blk_len_t   block_count_i,
    input  sdio_pkg::bus_width_e bus_width_i,
    input  logic [1:0]           pad_sel_i,
    input  logic                 dat_start_i,
    input  logic                 rx_en_i,
    input  sdio_pkg::lanes_t     dat_i,
    input  logic                 dma_rdy_i,
    output sdio_pkg::byte_t      dma_byte_o,
    output logic                 dma_wr_o,
    output logic                 crc_err_event_o,
    output logic                 end_err_event_o,
    output logic                 blk_end_event_o,
    output logic                 dat_done_o,
    output logic                 dat_busy_o,
    output logic                 clk_pause_o
);

    logic            push;
    sdio_pkg::byte_t push_byte;
    logic            full;
    logic            pop;
    sdio_pkg::byte_t pop_byte;
    logic            empty;

    sdio_rx_deser i_sdio_rx_deser (
        .sd_clk          (sd_clk),
        .rstn            (rstn),
        .sd_rst_i        (sd_rst_i),
        .block_size_i    (block_size_i),
        .block_count_i   (block_count_i),
        .bus_width_i     (bus_width_i),
        .pad_sel_i       (pad_sel_i),
        .dat_start_i     (dat_start_i),
        .rx_en_i         (rx_en_i),
        .dat_i           (dat_i),
        .full_i          (full),
        .push_o          (push),
        .push_byte_o     (push_byte),
        .crc_err_event_o (crc_err_event_o),
        .end_err_event_o (end_err_event_o),
        .blk_end_event_o (blk_end_event_o),
        .dat_done_o      (dat_done_o),
        .dat_busy_o      (dat_busy_o),
        .clk_pause_o     (clk_pause_o)
    );

    sdio_rx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_sdio_rx_fifo (
        .sd_clk      (sd_clk),
        .rstn        (rstn),
        .sd_rst_i    (sd_rst_i),
        .push_i      (push),
        .push_byte_i (push_byte),
        .full_o      (full),
        .pop_i       (pop),
        .pop_byte_o  (pop_byte),
        .empty_o     (empty)
    );

    sdio_dma_wr i_sdio_dma_wr (
        .sd_clk     (sd_clk),
        .rstn       (rstn),
        .sd_rst_i   (sd_rst_i),
        .empty_i    (empty),
        .pop_byte_i (pop_byte),
        .pop_o      (pop),
        .dma_rdy_i  (dma_rdy_i),
        .dma_byte_o (dma_byte_o),
        .dma_wr_o   (dma_wr_o)
    );

endmodule

//--- tb_sdio_rx_checker.sv
`timescale 1ns/1ps

module tb_sdio_rx_checker (
    input logic            sd_clk,
    input logic            rstn,
    input logic            dat_start_i,
    input logic            dma_wr_o,
    input sdio_pkg::byte_t dma_byte_o,
    input logic            crc_err_event_o,
    input logic            end_err_event_o,
    input logic            blk_end_event_o,
    input logic            dat_done_o,
    input logic            dat_busy_o,
    input logic            clk_pause_o
);

    sdio_pkg::byte_t exp_q [$];  // bytes sent by the card model
    int errors = 0;
    int n_blk = 0, n_crc = 0, n_end = 0, n_done = 0;
    int pause_run = 0;
    int stalls = 0;              // pauses longer than one cycle, i.e. fifo full
    logic start_seen;
    bit   busy_exp = 1'b0;

    // serial crc16 over one lane, first sent bit at index 0
    function automatic logic [15:0] crc16_ref(input logic [255:0] bits, input int n);
        logic [15:0] c;
        logic        fb;
        c = '0;
        for (int i = 0; i < n; i++) begin
            fb = bits[i] ^ c[15];
            c  = {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end
        return c;
    endfunction

    always @(posedge sd_clk)
        start_seen <= dat_start_i;

    // outputs are sampled away from the active edge
    always @(negedge sd_clk) begin
        if (rstn) begin
            if (dma_wr_o) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR t=%0t dma write with no byte left to expect", $time);
                    errors++;
                end else if (dma_byte_o !== exp_q[0]) begin
                    $display("MISMATCH t=%0t dma_byte_o exp %02h got %02h",
                             $time, exp_q[0], dma_byte_o);
                    errors++;
                    void'(exp_q.pop_front());
                end else begin
                    void'(exp_q.pop_front());
                end
            end
            if ((crc_err_event_o || end_err_event_o) && !blk_end_event_o) begin
                $display("ERROR t=%0t error event outside a block end", $time);
                errors++;
            end
            if (start_seen)
                busy_exp = 1'b1; // left idle on the start pulse
            if (dat_busy_o !== busy_exp) begin
                $display("MISMATCH t=%0t dat_busy_o exp %0b got %0b",
                         $time, busy_exp, dat_busy_o);
                errors++;
            end
            if (dat_done_o)
                busy_exp = 1'b0; // back to idle after the done cycle
            n_blk  += blk_end_event_o;
            n_crc  += crc_err_event_o;
            n_end  += end_err_event_o;
            n_done += dat_done_o;
            pause_run = clk_pause_o ? pause_run + 1 : 0;
            if (pause_run == 2)
                stalls++;
        end
    end

    task automatic compare_count(input string name, input int exp, input int got);
        if (exp != got) begin
            $display("MISMATCH t=%0t %s count exp %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_counts(input int blk, input int crc, input int endb);
        compare_count("blk_end_event_o", blk, n_blk);
        compare_count("crc_err_event_o", crc, n_crc);
        compare_count("end_err_event_o", endb, n_end);
        compare_count("dat_done_o", 1, n_done);
        n_blk  = 0;
        n_crc  = 0;
        n_end  = 0;
        n_done = 0;
    endtask

endmodule

//--- tb_sdio_rx.sv
`timescale 1ns/1ps

module tb_sdio_rx;

    logic sd_clk = 1'b0;
    logic rstn, sd_rst_i, dat_start_i, rx_en_i, dma_rdy_i;
    sdio_pkg::blk_len_t   block_size_i, block_count_i;
    sdio_pkg::bus_width_e bus_width_i;
    logic [1:0]           pad_sel_i;
    sdio_pkg::lanes_t     dat_i;
    sdio_pkg::byte_t      dma_byte_o;
    logic dma_wr_o, crc_err_event_o, end_err_event_o, blk_end_event_o;
    logic dat_done_o, dat_busy_o, clk_pause_o;

    integer seed = 32'hf6e1;
    int     cycles = 0;
    int     limit;
    int     tb_errors = 0;
    bit     cur_four, cur_noise, rdy_random;
    int     stretch = 0;

    always #4 sd_clk = ~sd_clk;

    sdio_rx_top #(.FIFO_DEPTH(8)) i_sdio_rx_top (.*);

    tb_sdio_rx_checker i_checker (.*);

    // long random gaps of dma ready
    always @(negedge sd_clk) begin
        if (!rdy_random) begin
            dma_rdy_i = 1'b1;
        end else if (stretch == 0) begin
            dma_rdy_i = ~dma_rdy_i;
            stretch   = dma_rdy_i ? 4 : ($random(seed) & 63) + 40;
        end else begin
            stretch--;
        end
    end

    always @(posedge sd_clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("ERROR timeout after %0d cycles, transfer never finished", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // one card bit every third cycle, held off while the clock is paused
    task automatic drive_bit(input logic [3:0] val);
        logic [3:0] smp;
        repeat (2) @(negedge sd_clk);
        while (clk_pause_o)
            @(negedge sd_clk);
        if (cur_four) begin
            smp = val;
        end else begin
            smp = cur_noise ? 4'($random(seed)) : 4'hf;
            smp[pad_sel_i] = val[0];
        end
        dat_i   = smp;
        rx_en_i = 1'b1;
        @(negedge sd_clk);
        rx_en_i = 1'b0;
    endtask

    task automatic send_block(input int nbytes, input bit flip, input bit bad_end);
        logic [255:0] strm [4];
        logic [15:0]  crc [4];
        logic [3:0]   smp [256];
        logic [7:0]   b;
        int           k;
        k = 0;
        for (int i = 0; i < nbytes; i++) begin
            b = 8'($random(seed));
            i_checker.exp_q.push_back(b);
            for (int s = 0; s < (cur_four ? 2 : 8); s++) begin
                smp[k] = cur_four ? (s == 0 ? b[7:4] : b[3:0]) : {3'b111, b[7-s]};
                for (int l = 0; l < 4; l++)
                    strm[l][k] = smp[k][l];
                k++;
            end
        end
        for (int l = 0; l < 4; l++)
            crc[l] = i_checker.crc16_ref(strm[l], k);
        drive_bit(4'h0);  // start bit
        for (int i = 0; i < k; i++)
            drive_bit(smp[i]);
        for (int j = 0; j < 16; j++)
            drive_bit({crc[3][15-j], crc[2][15-j] ^ (flip && j == 5),
                       crc[1][15-j], crc[0][15-j]});
        drive_bit(bad_end ? 4'h0 : 4'hf);
    endtask

    task automatic run_xfer(input int nblk, input int size, input bit four, input int pad,
                            input int flip_blk, input int bad_blk, input bit noise);
        @(negedge sd_clk);
        block_size_i  = 16'(size);
        block_count_i = 16'(nblk);
        bus_width_i   = four ? sdio_pkg::BUS_4BIT : sdio_pkg::BUS_1BIT;
        pad_sel_i     = 2'(pad);
        cur_four      = four;
        cur_noise     = noise;
        dat_start_i   = 1'b1;
        @(negedge sd_clk);
        dat_start_i = 1'b0;
        for (int n = 0; n < nblk; n++)
            send_block(size, n == flip_blk, n == bad_blk);
        while (dat_busy_o || i_checker.exp_q.size() != 0)
            @(negedge sd_clk);
        repeat (3) @(negedge sd_clk);
        i_checker.check_counts(nblk, flip_blk >= 0, bad_blk >= 0);
    endtask

    function automatic int frame_bits(input int nblk, input int size, input bit four);
        return nblk * (size * (four ? 2 : 8) + 18);
    endfunction

    initial begin
        rstn = 1'b0;
        sd_rst_i = 1'b0;
        dat_start_i = 1'b0;
        rx_en_i = 1'b0;
        dat_i = 4'hf;
        dma_rdy_i = 1'b1;
        rdy_random = 1'b0;
        block_size_i = '0;
        block_count_i = '0;
        bus_width_i = sdio_pkg::BUS_1BIT;
        pad_sel_i = '0;
        limit = 3 * 3 * (frame_bits(1, 16, 0) + frame_bits(3, 32, 1) + frame_bits(3, 16, 1)
                + frame_bits(2, 8, 0) + frame_bits(3, 32, 1) + frame_bits(1, 16, 0)) + 1000;
        repeat (5) @(negedge sd_clk);
        rstn = 1'b1;

        run_xfer(1, 16, 0, 0, -1, -1, 0);
        run_xfer(3, 32, 1, 0, -1, -1, 0);
        run_xfer(3, 16, 1, 0, 1, -1, 0);   // crc flip on lane 2, block 1
        run_xfer(2, 8, 0, 0, -1, 0, 0);    // low end bit on block 0
        rdy_random = 1'b1;
        run_xfer(3, 32, 1, 0, -1, -1, 0);
        rdy_random = 1'b0;
        if (i_checker.stalls == 0) begin
            $display("ERROR clk_pause_o never held for a full fifo");
            tb_errors++;
        end
        run_xfer(1, 16, 0, 2, -1, -1, 1);  // pad lane 2, noise elsewhere

        $display("checks done, %0d errors", tb_errors + i_checker.errors);
        if (tb_errors + i_checker.errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- vlog.f
sdio_pkg.sv
sdio_crc16.sv
sdio_rx_deser.sv
sdio_rx_fifo.sv
sdio_dma_wr.sv
sdio_rx_top.sv
tb_sdio_rx_checker.sv
tb_sdio_rx.sv

//--- Bender.yml
package:
  name: sdio_rx

sources:
  - sdio_pkg.sv
  - sdio_crc16.sv
  - sdio_rx_deser.sv
  - sdio_rx_fifo.sv
  - sdio_dma_wr.sv
  - sdio_rx_top.sv
  - target: test
    files:
      - tb_sdio_rx_checker.sv
      - tb_sdio_rx.sv
